// ==== rtl/fetch_pkg.sv ====
// Fetch package
// Shared widths and the structs used on the memory, decode, commit and
// squash channels of the fetch stage

package fetch_pkg;

  // Sequence numbers and ROM size
  localparam int SEQ_NUM_BITS = 5;
  localparam int ROM_WORDS    = 32;

  // ----------------------------------------------------------------------
  // Memory channel
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic [31:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } mem_resp_t;

  // ----------------------------------------------------------------------
  // Decode, commit and squash
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic                    val;
    logic [31:0]             pc;
    logic [31:0]             inst;
    logic [SEQ_NUM_BITS-1:0] seq_num;
  } fetch_bundle_t;

  // Numbers retired this cycle, 0 up to the reclaim width
  typedef struct packed {
    logic [2:0] count;
  } commit_notif_t;

  typedef struct packed {
    logic                    val;
    logic [31:0]             target;
    logic [SEQ_NUM_BITS-1:0] seq_num;
  } squash_notif_t;

endpackage

// ==== rtl/seq_num_gen.sv ====
// Sequence-number allocator
// Hands out numbers in order, reclaims up to p_reclaim_width per cycle on
// commit and rewinds the tail on squash

`timescale 1ns/1ps

module seq_num_gen import fetch_pkg::*; #(
  parameter int p_reclaim_width = 2
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    alloc_take,
  input  commit_notif_t           commit,
  input  squash_notif_t           squash,
  output logic                    alloc_val,
  output logic [SEQ_NUM_BITS-1:0] alloc_seq_num
);

  // One number always stays free so full and empty differ
  localparam logic [SEQ_NUM_BITS-1:0] MAX_LIVE = '1;

  logic [SEQ_NUM_BITS-1:0] head;
  logic [SEQ_NUM_BITS-1:0] tail;
  logic [SEQ_NUM_BITS-1:0] live;
  logic [2:0]              reclaim;

  // ----------------------------------------------------------------------
  // Occupancy and offer
  // ----------------------------------------------------------------------

  always_comb begin
    // Distance tail to head, wraps with the pointer width
    live          = tail - head;
    alloc_val     = live < MAX_LIVE;
    alloc_seq_num = tail;
    // Clamp to the lanes we actually have
    if (commit.count > 3'(p_reclaim_width)) begin
      reclaim = 3'(p_reclaim_width);
    end else begin
      reclaim = commit.count;
    end
  end

  // ----------------------------------------------------------------------
  // Head and tail pointers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      tail <= '0;
    end else begin
      // Oldest uncommitted moves on commit
      head <= head + SEQ_NUM_BITS'(reclaim);
      // Squash wins over a take in the same cycle
      if (squash.val) begin
        tail <= squash.seq_num + 1'b1;
      end else if (alloc_take) begin
        tail <= tail + 1'b1;
      end
    end
  end

endmodule

// ==== rtl/fetch_unit.sv ====
// Fetch unit
// Issues sequential instruction reads with several in flight, drops
// stale responses after a squash and hands bundles to decode

`timescale 1ns/1ps

module fetch_unit import fetch_pkg::*; #(
  parameter logic [31:0] p_rst_addr      = 32'h200,
  parameter int          p_max_in_flight = 8,
  parameter int          p_reclaim_width = 2
) (
  input  logic          clk,
  input  logic          rst,
  output mem_req_t      mem_req,
  output logic          mem_req_val,
  input  logic          mem_req_rdy,
  input  mem_resp_t     mem_resp,
  input  logic          mem_resp_val,
  output logic          mem_resp_rdy,
  output fetch_bundle_t fetch_out,
  input  logic          inst_rdy,
  input  commit_notif_t commit,
  input  squash_notif_t squash
);

  localparam int FLIGHT_BITS = $clog2(p_max_in_flight) + 1;

  logic                    req_xfer;
  logic                    resp_xfer;
  logic                    drop;
  logic [FLIGHT_BITS-1:0]  in_flight;
  logic [FLIGHT_BITS-1:0]  in_flight_next;
  logic [FLIGHT_BITS-1:0]  to_squash;
  logic [FLIGHT_BITS-1:0]  to_squash_next;
  logic [FLIGHT_BITS:0]    outstanding;
  logic [31:0]             curr_addr;
  logic                    alloc_val;
  logic                    alloc_take;
  logic [SEQ_NUM_BITS-1:0] alloc_seq_num;

  assign req_xfer  = mem_req_val & mem_req_rdy;
  assign resp_xfer = mem_resp_val & mem_resp_rdy;

  // Everything in the squash cycle or owed from an older squash is stale
  assign drop = squash.val | (to_squash != '0);

  // ----------------------------------------------------------------------
  // In-flight and to-squash counters
  // ----------------------------------------------------------------------

  always_comb begin
    in_flight_next = in_flight;
    // Squash hands all live reads over to the drop counter
    if (squash.val) begin
      in_flight_next = '0;
    end
    if (req_xfer && (!resp_xfer || drop)) begin
      in_flight_next = in_flight_next + 1'b1;
    end
    if (resp_xfer && !req_xfer && !drop) begin
      in_flight_next = in_flight_next - 1'b1;
    end
  end

  always_comb begin
    to_squash_next = to_squash;
    if (squash.val) begin
      to_squash_next = to_squash_next + in_flight;
    end
    // Each dropped response pays one back
    if (resp_xfer && (to_squash_next != '0)) begin
      to_squash_next = to_squash_next - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= '0;
      to_squash <= '0;
    end else begin
      in_flight <= in_flight_next;
      to_squash <= to_squash_next;
    end
  end

  // ----------------------------------------------------------------------
  // Request address and issue
  // ----------------------------------------------------------------------

  always_comb begin
    mem_req.addr = squash.val ? squash.target : curr_addr;
    outstanding  = {1'b0, in_flight} + {1'b0, to_squash};
    mem_req_val  = outstanding < (FLIGHT_BITS + 1)'(p_max_in_flight);
  end

  // Target on squash, target plus 4 if it was sent the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      curr_addr <= p_rst_addr;
    end else if (req_xfer) begin
      curr_addr <= mem_req.addr + 32'd4;
    end else if (squash.val) begin
      curr_addr <= squash.target;
    end
  end

  // ----------------------------------------------------------------------
  // Sequence numbers and decode hand-off
  // ----------------------------------------------------------------------

  seq_num_gen #(
    .p_reclaim_width (p_reclaim_width)
  ) i_seq_num_gen (
    .clk           (clk),
    .rst           (rst),
    .alloc_take    (alloc_take),
    .commit        (commit),
    .squash        (squash),
    .alloc_val     (alloc_val),
    .alloc_seq_num (alloc_seq_num)
  );

  always_comb begin
    // Stale responses are swallowed without waiting on decode
    mem_resp_rdy      = (inst_rdy & alloc_val) | drop;
    fetch_out.val     = mem_resp_val & alloc_val & !drop;
    fetch_out.pc      = mem_resp.addr;
    fetch_out.inst    = mem_resp.data;
    fetch_out.seq_num = alloc_seq_num;
    alloc_take        = fetch_out.val & inst_rdy;
  end

endmodule

// ==== rtl/inst_rom.sv ====
// Instruction ROM
// Fixed-latency read pipeline feeding an in-order response queue, with
// credit-based ready so accepted reads always have a slot

`timescale 1ns/1ps

module inst_rom import fetch_pkg::*; #(
  parameter int p_rom_latency   = 2,
  parameter int p_max_in_flight = 8
) (
  input  logic      clk,
  input  logic      rst,
  input  mem_req_t  req,
  input  logic      req_val,
  output logic      req_rdy,
  output mem_resp_t resp,
  output logic      resp_val,
  input  logic      resp_rdy
);

  localparam int IDX_BITS = $clog2(ROM_WORDS);
  localparam int PTR_BITS = $clog2(p_max_in_flight);
  localparam int CNT_BITS = PTR_BITS + 1;

  logic [31:0]         rom [ROM_WORDS];
  logic                pipe_val [p_rom_latency];
  mem_resp_t           pipe_resp [p_rom_latency];
  mem_resp_t           q_mem [p_max_in_flight];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] q_count;
  logic [CNT_BITS-1:0] used;
  logic                q_empty;
  logic                req_xfer;
  logic                resp_xfer;
  logic                push;
  logic                pop;

  initial begin
    $readmemh("verif/inst.hex", rom);
  end

  // ----------------------------------------------------------------------
  // Credits and output select
  // ----------------------------------------------------------------------

  always_comb begin
    // Queue plus pipeline never exceed the queue depth
    req_rdy   = used < CNT_BITS'(p_max_in_flight);
    req_xfer  = req_val & req_rdy;
    q_empty   = q_count == '0;
    // Bypass the queue when it is empty
    resp_val  = !q_empty | pipe_val[p_rom_latency-1];
    resp      = q_empty ? pipe_resp[p_rom_latency-1] : q_mem[rd_ptr];
    resp_xfer = resp_val & resp_rdy;
    pop       = !q_empty & resp_rdy;
    push      = pipe_val[p_rom_latency-1] & !(q_empty & resp_rdy);
  end

  // ----------------------------------------------------------------------
  // Read pipeline
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < p_rom_latency; i++) begin
        pipe_val[i] <= 1'b0;
      end
    end else begin
      pipe_val[0] <= req_xfer;
      for (int i = 1; i < p_rom_latency; i++) begin
        pipe_val[i] <= pipe_val[i-1];
      end
    end
  end

  // Payload moves with no reset
  always_ff @(posedge clk) begin
    pipe_resp[0].addr <= req.addr;
    pipe_resp[0].data <= rom[req.addr[IDX_BITS+1:2]];
    for (int i = 1; i < p_rom_latency; i++) begin
      pipe_resp[i] <= pipe_resp[i-1];
    end
    if (push) begin
      q_mem[wr_ptr] <= pipe_resp[p_rom_latency-1];
    end
  end

  // ----------------------------------------------------------------------
  // Queue pointers and credit count
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
      used    <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(p_max_in_flight - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(p_max_in_flight - 1)) ? '0 : rd_ptr + 1'b1;
      end
      q_count <= q_count + CNT_BITS'(push) - CNT_BITS'(pop);
      used    <= used + CNT_BITS'(req_xfer) - CNT_BITS'(resp_xfer);
    end
  end

endmodule

// ==== rtl/fetch_top.sv ====
// Fetch top level
// Fetch unit wired to the instruction ROM, parameters set here

`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
  parameter logic [31:0] p_rst_addr      = 32'h200,
  parameter int          p_max_in_flight = 8,
  parameter int          p_reclaim_width = 2,
  parameter int          p_rom_latency   = 2
) (
  input  logic          clk,
  input  logic          rst,
  output fetch_bundle_t fetch_out,
  input  logic          inst_rdy,
  input  commit_notif_t commit,
  input  squash_notif_t squash
);

  // Memory request and response channels
  mem_req_t  mem_req;
  logic      mem_req_val;
  logic      mem_req_rdy;
  mem_resp_t mem_resp;
  logic      mem_resp_val;
  logic      mem_resp_rdy;

  fetch_unit #(
    .p_rst_addr      (p_rst_addr),
    .p_max_in_flight (p_max_in_flight),
    .p_reclaim_width (p_reclaim_width)
  ) i_fetch_unit (
    .clk          (clk),
    .rst          (rst),
    .mem_req      (mem_req),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp     (mem_resp),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy),
    .fetch_out    (fetch_out),
    .inst_rdy     (inst_rdy),
    .commit       (commit),
    .squash       (squash)
  );

  // Queue depth matches the fetch in-flight limit
  inst_rom #(
    .p_rom_latency   (p_rom_latency),
    .p_max_in_flight (p_max_in_flight)
  ) i_inst_rom (
    .clk      (clk),
    .rst      (rst),
    .req      (mem_req),
    .req_val  (mem_req_val),
    .req_rdy  (mem_req_rdy),
    .resp     (mem_resp),
    .resp_val (mem_resp_val),
    .resp_rdy (mem_resp_rdy)
  );

endmodule

// ==== verif/tb_fetch_top.sv ====
// Fetch stage testbench
// Plays decode, commit and squash around fetch_top and checks every bundle
// against an in-order pc, ROM word and sequence-number model

`timescale 1ns/1ps

module tb_fetch_top import fetch_pkg::*; ();

  localparam logic [31:0] RST_ADDR       = 32'h200;
  localparam int          MAX_IN_FLIGHT  = 8;
  localparam int          RECLAIM_WIDTH  = 2;
  localparam int          ROM_LATENCY    = 2;
  localparam int          CLK_PERIOD     = 40;
  localparam int          RST_CYCLES     = 8;
  localparam int          TIMEOUT_CYCLES = 300;
  localparam int          SETTLE_CYCLES  = 20;
  localparam int          NUM_TESTS      = 6;
  // Largest live count that still leaves one number free
  localparam int          MAX_LIVE       = (1 << SEQ_NUM_BITS) - 1;

  // Commit policies
  localparam int COMMIT_NONE = 0;
  localparam int COMMIT_ONE  = 1;
  localparam int COMMIT_FULL = 2;

  typedef struct packed {
    int          ready_pct;
    int          bundles;
    int          sq_cycle;      // 0 means no squash
    logic [31:0] sq_target;
    int          sq_back;       // distance behind the youngest delivered number
    int          commit_mode;
    int          commit_delay;
  } test_row_t;

  logic          clk;
  logic          rst;
  logic          inst_rdy;
  commit_notif_t commit;
  squash_notif_t squash;
  fetch_bundle_t fetch_out;

  test_row_t               rows [NUM_TESTS];
  string                   test_names [NUM_TESTS];
  logic [31:0]             model_rom [ROM_WORDS];
  logic [31:0]             exp_pc;
  logic [SEQ_NUM_BITS-1:0] exp_seq;
  logic [SEQ_NUM_BITS-1:0] head;
  fetch_bundle_t           held;
  logic                    held_val;
  int                      errors;
  int                      checks;
  int                      test_errors;
  int                      tests_run;
  bit                      timed_out;

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  fetch_top #(
    .p_rst_addr      (RST_ADDR),
    .p_max_in_flight (MAX_IN_FLIGHT),
    .p_reclaim_width (RECLAIM_WIDTH),
    .p_rom_latency   (ROM_LATENCY)
  ) i_fetch_top (
    .clk       (clk),
    .rst       (rst),
    .fetch_out (fetch_out),
    .inst_rdy  (inst_rdy),
    .commit    (commit),
    .squash    (squash)
  );

  // ----------------------------------------------------------------------
  // Checking helpers
  // ----------------------------------------------------------------------

  task automatic report_error(input string msg);
    errors++;
    test_errors++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  // Delivered bundle against the model, then advance the model
  task automatic check_bundle();
    logic [31:0] exp_inst;
    exp_inst = model_rom[exp_pc[6:2]];
    checks++;
    if (fetch_out.pc != exp_pc || fetch_out.inst != exp_inst ||
        fetch_out.seq_num != exp_seq) begin
      report_error($sformatf("got pc %h inst %h seq %0d, expected pc %h inst %h seq %0d",
                             fetch_out.pc, fetch_out.inst, fetch_out.seq_num,
                             exp_pc, exp_inst, exp_seq));
    end
    exp_pc  = exp_pc + 32'd4;
    exp_seq = exp_seq + 1'b1;
  endtask

  task automatic reset_dut();
    @(negedge clk);
    rst      = 1'b1;
    inst_rdy = 1'b0;
    commit   = '0;
    squash   = '0;
    repeat (RST_CYCLES) @(negedge clk);
    rst      = 1'b0;
    exp_pc   = RST_ADDR;
    exp_seq  = '0;
    head     = '0;
    held_val = 1'b0;
    #(CLK_PERIOD / 4);
    // Nothing offered straight out of reset
    checks++;
    if (fetch_out.val || i_fetch_top.mem_resp_val) begin
      report_error("valid output right after reset");
    end
  endtask

  // ----------------------------------------------------------------------
  // One clock of decode, commit and squash
  // ----------------------------------------------------------------------

  task automatic step_cycle(input test_row_t row, input int cycle, output bit delivered);
    logic [SEQ_NUM_BITS-1:0] live;
    logic [SEQ_NUM_BITS-1:0] sq_seq;
    int                      back;
    int                      take;
    bit                      sq_now;
    delivered = 1'b0;
    sq_seq    = '0;
    live      = exp_seq - head;
    sq_now    = (row.sq_cycle != 0) && (cycle == row.sq_cycle);
    @(negedge clk);
    inst_rdy = (($urandom % 100) < row.ready_pct);
    // Commit only numbers that were handed out
    take = 0;
    if (!sq_now && cycle >= row.commit_delay) begin
      if (row.commit_mode == COMMIT_FULL) begin
        take = RECLAIM_WIDTH;
      end else if (row.commit_mode == COMMIT_ONE && cycle == row.commit_delay) begin
        take = 1;
      end
    end
    if (take > int'(live)) begin
      take = int'(live);
    end
    commit.count = 3'(take);
    squash       = '0;
    if (sq_now) begin
      // Squashing instruction is a live one, never older than head
      back = row.sq_back;
      if (live == '0) begin
        back = 0;
      end else if (back > int'(live) - 1) begin
        back = int'(live) - 1;
      end
      sq_seq         = exp_seq - 1'b1 - SEQ_NUM_BITS'(back);
      squash.val     = 1'b1;
      squash.target  = row.sq_target;
      squash.seq_num = sq_seq;
    end
    // Sample mid-way, well clear of both edges
    #(CLK_PERIOD / 4);
    if (sq_now) begin
      checks++;
      if (fetch_out.val) begin
        report_error("bundle offered in the squash cycle");
      end
      held_val = 1'b0;
      exp_pc   = row.sq_target;
      exp_seq  = sq_seq + 1'b1;
    end else begin
      if (held_val) begin
        checks++;
        if (fetch_out != held) begin
          report_error("bundle changed while decode stalled");
        end
      end
      held_val = 1'b0;
      if (fetch_out.val) begin
        checks++;
        if (int'(live) >= MAX_LIVE) begin
          report_error("bundle offered with all sequence numbers in use");
        end
        if (inst_rdy) begin
          check_bundle();
          delivered = 1'b1;
        end else begin
          held     = fetch_out;
          held_val = 1'b1;
        end
      end
    end
    head = head + SEQ_NUM_BITS'(take);
  endtask

  // ----------------------------------------------------------------------
  // One table row
  // ----------------------------------------------------------------------

  task automatic run_test(input int idx);
    test_row_t row;
    test_row_t idle_row;
    int        cycle;
    int        idle;
    int        collected;
    bit        delivered;
    row         = rows[idx];
    idle_row    = '{0, 0, 0, 32'h0, 0, COMMIT_NONE, 0};
    test_errors = 0;
    collected   = 0;
    cycle       = 0;
    idle        = 0;
    reset_dut();
    // Bundle wait, bounded by the idle count
    while (collected < row.bundles && !timed_out) begin
      cycle++;
      step_cycle(row, cycle, delivered);
      if (delivered) begin
        collected++;
        idle = 0;
      end else begin
        idle++;
        // Full ready plus full-width reclaim must never starve
        if (row.ready_pct == 100 && row.commit_mode == COMMIT_FULL && collected > 0) begin
          report_error("gap in the stream with decode ready and commits flowing");
        end
        if (idle >= TIMEOUT_CYCLES) begin
          $display("Timeout: test %0d waited %0d cycles for bundle %0d and none came",
                   idx, idle, collected + 1);
          timed_out = 1'b1;
        end
      end
    end
    // Decode stalled, no commits, watch for anything extra
    if (!timed_out) begin
      repeat (SETTLE_CYCLES) step_cycle(idle_row, 0, delivered);
    end
    tests_run++;
    $display("test %0d %s: %0d of %0d bundles, %0d errors",
             idx, test_names[idx], collected, row.bundles, test_errors);
  endtask

  // ----------------------------------------------------------------------
  // Stimulus table and main flow
  // ----------------------------------------------------------------------

  initial begin
    int idx;
    rst       = 1'b1;
    inst_rdy  = 1'b0;
    commit    = '0;
    squash    = '0;
    held      = '0;
    held_val  = 1'b0;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    timed_out = 1'b0;
    void'($urandom(77));
    $readmemh("verif/inst.hex", model_rom);

    // ready, bundles, squash cycle, target, back, commits, commit delay
    rows[0] = '{100, 24, 0,  32'h0,   0, COMMIT_NONE, 0};
    rows[1] = '{40,  40, 0,  32'h0,   0, COMMIT_FULL, 0};
    rows[2] = '{100, 25, 12, 32'h240, 3, COMMIT_NONE, 0};
    rows[3] = '{100, 32, 0,  32'h0,   0, COMMIT_ONE,  100};
    rows[4] = '{100, 70, 0,  32'h0,   0, COMMIT_FULL, 0};
    rows[5] = '{10,  20, 40, 32'h2a0, 1, COMMIT_FULL, 60};
    test_names[0] = "straight line";
    test_names[1] = "decode back-pressure";
    test_names[2] = "squash in flight";
    test_names[3] = "sequence exhaustion";
    test_names[4] = "multi-lane reclaim";
    test_names[5] = "squash with full queue";

    idx = 0;
    while (idx < NUM_TESTS && !timed_out) begin
      run_test(idx);
      idx++;
    end

    $display("tests %0d of %0d, checks %0d, errors %0d, timeout %0d",
             tests_run, NUM_TESTS, checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== verif/inst.hex ====
// One 32-bit instruction word per line, ROM index 0 to 31
// Index is address bits 6:2, so index 0 is fetched at 0x200
00000093
00100113
00200193
00300213
00400293
00500313
00600393
00700413
00800493
00900513
00a00593
00b00613
00c00693
00d00713
00e00793
00f00813
01000893
01100913
01200993
01300a13
01400a93
01500b13
01600b93
01700c13
01800c93
01900d13
01a00d93
01b00e13
01c00e93
01d00f13
01e00f93
01f00093

// ==== project.f ====
rtl/fetch_pkg.sv
rtl/seq_num_gen.sv
rtl/fetch_unit.sv
rtl/inst_rom.sv
rtl/fetch_top.sv
verif/tb_fetch_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_fetch_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "NO ERRORS" $(LOG) && echo "Simulation passed" || (echo "Simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
